// File: hw/pio_pkg.sv
// Shared widths, opcode and field encodings for the PIO state machine
// Imported by wildcard into every module and interface that needs them

package pio_pkg;

  localparam int WORD_W  = 32;                     // Data and pin word
  localparam int INSTR_W = 16;
  localparam int PC_W    = 5;

  // Major opcodes, instruction bits 15:13
  localparam logic [2:0] OP_JMP      = 3'd0;
  localparam logic [2:0] OP_IN       = 3'd2;
  localparam logic [2:0] OP_OUT      = 3'd3;
  localparam logic [2:0] OP_PUSHPULL = 3'd4;
  localparam logic [2:0] OP_MOV      = 3'd5;
  localparam logic [2:0] OP_SET      = 3'd7;

  // Source and destination codes shared by IN, OUT, MOV and SET
  localparam logic [2:0] LOC_PINS    = 3'd0;
  localparam logic [2:0] LOC_X       = 3'd1;
  localparam logic [2:0] LOC_Y       = 3'd2;
  localparam logic [2:0] LOC_NULL    = 3'd3;
  localparam logic [2:0] LOC_PINDIRS = 3'd4;

  localparam logic [1:0] MOV_INVERT  = 2'd1;
  localparam logic [1:0] MOV_REVERSE = 2'd2;

  localparam logic [5:0] BIT_COUNT_FULL = 6'd32;   // Zero count field, also full threshold

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] ignored;                           // Old delay and side-set bits
    logic [2:0] op1;                               // Condition, source or destination
    logic [4:0] op2;                               // Address, bit count or data
  } flow_view_t;

  typedef struct packed {
    logic [2:0] op;
    logic [4:0] ignored;
    logic [2:0] dst;
    logic [1:0] mov_op;
    logic [2:0] src;
  } mov_view_t;

  typedef union packed {
    flow_view_t flow;
    mov_view_t  mov;
  } instr_t;

endpackage

// File: hw/pio_ifs.sv
// Interfaces between fetch, execute, shift and pin stages of the PIO machine
// The execute stage is the master on all three

`timescale 1ns/10ps

interface fetch_if import pio_pkg::*; ();
  instr_t          instr;                          // Current instruction word
  logic            jmp;                            // Taken jump
  logic [PC_W-1:0] new_pc;
  logic            stall;                          // Hold pc, retry instruction

  modport fetch (output instr, input jmp, input new_pc, input stall);
  modport exec (input instr, output jmp, output new_pc, output stall);
endinterface

interface shift_if import pio_pkg::*; ();
  logic              set_isr;
  logic [WORD_W-1:0] isr_val;
  logic              in_shift;
  logic [WORD_W-1:0] in_src;                       // Bits to shift into ISR
  logic              set_osr;                      // OSR load, count goes to 0
  logic [WORD_W-1:0] osr_val;
  logic              out_shift;
  logic [5:0]        bit_count;                    // 1 to 32
  logic [WORD_W-1:0] isr;
  logic [WORD_W-1:0] osr;
  logic [5:0]        osr_count;
  logic [WORD_W-1:0] out_bits;                     // Bits leaving the OSR, right aligned

  modport exec (output set_isr, isr_val, in_shift, in_src, set_osr, osr_val,
                output out_shift, bit_count, input isr, osr, osr_count, out_bits);
  modport shifter (input set_isr, isr_val, in_shift, in_src, set_osr, osr_val,
                   input out_shift, bit_count, output isr, osr, osr_count, out_bits);
endinterface

interface pin_if import pio_pkg::*; ();
  logic              write_pins;
  logic              write_dirs;
  logic              use_set_window;               // SET window, else OUT window
  logic [WORD_W-1:0] value;                        // Bit 0 goes to the window base

  modport exec (output write_pins, write_dirs, use_set_window, value);
  modport out (input write_pins, write_dirs, use_set_window, value);
endinterface

// File: hw/pio_fetch.sv
// Program counter of the PIO machine, with jump, stall and wrap handling
// The instruction word from the external program store passes straight through

`timescale 1ns/10ps

module pio_fetch import pio_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  logic [PC_W-1:0]    pend,
  input  logic [PC_W-1:0]    wrap_target,
  output logic [PC_W-1:0]    pc,
  input  logic [INSTR_W-1:0] instr_word,
  fetch_if.fetch             fetch
);

  // Program store is read asynchronously at pc
  assign fetch.instr = instr_word;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (en && !fetch.stall) begin
      if (fetch.jmp) begin
        pc <= fetch.new_pc;                        // Taken jump beats wrap
      end else if (pc == pend) begin
        pc <= wrap_target;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

endmodule

// File: hw/pio_exec.sv
// Execute stage of the PIO machine: decodes the current instruction, holds X and Y,
// and drives the shifter, the pin writes and the FIFO strobes in the same cycle

`timescale 1ns/10ps

module pio_exec import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  fetch_if.exec             fetch,
  shift_if.exec             shift,
  pin_if.exec               pins,
  input  logic [WORD_W-1:0] in_pins,
  input  logic [4:0]        in_base,
  input  logic [4:0]        jmp_pin,
  input  logic [WORD_W-1:0] tx_data,
  input  logic              tx_empty,
  input  logic              rx_full,
  output logic              pull,
  output logic              push,
  output logic [WORD_W-1:0] rx_data
);

  instr_t              ins;
  logic [WORD_W-1:0]   x;
  logic [WORD_W-1:0]   y;
  logic [WORD_W-1:0]   new_x;
  logic [WORD_W-1:0]   new_y;
  logic                set_x;
  logic                set_y;
  logic                dec_x;
  logic                dec_y;
  logic [2*WORD_W-1:0] pins_wide;
  logic [WORD_W-1:0]   pins_rot;
  logic [WORD_W-1:0]   mov_val;
  logic                blocking;

  function automatic logic [WORD_W-1:0] pick_src(input logic [2:0] code,
                                                 input logic [WORD_W-1:0] p,
                                                 input logic [WORD_W-1:0] vx,
                                                 input logic [WORD_W-1:0] vy);
    case (code)
      LOC_PINS: pick_src = p;
      LOC_X:    pick_src = vx;
      LOC_Y:    pick_src = vy;
      default:  pick_src = '0;                     // NULL
    endcase
  endfunction

  function automatic logic [WORD_W-1:0] bit_op(input logic [WORD_W-1:0] v,
                                               input logic [1:0] op);
    case (op)
      MOV_INVERT:  bit_op = ~v;
      MOV_REVERSE: bit_op = {<<{v}};
      default:     bit_op = v;                     // Plain, 3 is reserved
    endcase
  endfunction

  assign ins       = fetch.instr;
  assign pins_wide = {in_pins, in_pins} >> in_base; // Rotate so in_base lands on bit 0
  assign pins_rot  = pins_wide[WORD_W-1:0];
  assign mov_val   = bit_op(pick_src(ins.mov.src, pins_rot, x, y), ins.mov.mov_op);
  assign blocking  = ins.flow.op1[0];
  assign rx_data   = shift.isr;

  always_comb begin
    fetch.jmp            = 1'b0;
    fetch.new_pc         = ins.flow.op2;
    fetch.stall          = 1'b0;
    shift.set_isr        = 1'b0;
    shift.isr_val        = '0;                     // Only load is the clear on push
    shift.in_shift       = 1'b0;
    shift.in_src         = pick_src(ins.flow.op1, pins_rot, x, y);
    shift.set_osr        = 1'b0;
    shift.osr_val        = tx_empty ? x : tx_data;
    shift.out_shift      = 1'b0;
    shift.bit_count      = (ins.flow.op2 == '0) ? BIT_COUNT_FULL : {1'b0, ins.flow.op2};
    pins.write_pins      = 1'b0;
    pins.write_dirs      = 1'b0;
    pins.use_set_window  = (ins.flow.op == OP_SET);
    pins.value           = (ins.flow.op == OP_SET) ? WORD_W'(ins.flow.op2) : shift.out_bits;
    set_x = 1'b0;
    set_y = 1'b0;
    dec_x = 1'b0;
    dec_y = 1'b0;
    new_x = shift.out_bits;
    new_y = shift.out_bits;
    pull  = 1'b0;
    push  = 1'b0;
    if (en) begin
      case (ins.flow.op)
        OP_JMP: begin
          case (ins.flow.op1)
            3'd0: fetch.jmp = 1'b1;
            3'd1: fetch.jmp = (x == '0);
            3'd2: begin
              fetch.jmp = (x != '0);
              dec_x     = (x != '0);               // X-- decrements after the test
            end
            3'd3: fetch.jmp = (y == '0);
            3'd4: begin
              fetch.jmp = (y != '0);
              dec_y     = (y != '0);
            end
            3'd5: fetch.jmp = (x != y);
            3'd6: fetch.jmp = in_pins[jmp_pin];    // Absolute pin, no in_base
            default: fetch.jmp = (shift.osr_count < BIT_COUNT_FULL); // !OSRE
          endcase
        end
        OP_IN: shift.in_shift = (ins.flow.op1 <= LOC_NULL);
        OP_OUT: begin
          shift.out_shift = (ins.flow.op1 <= LOC_PINDIRS);
          case (ins.flow.op1)
            LOC_PINS:    pins.write_pins = 1'b1;
            LOC_X:       set_x = 1'b1;
            LOC_Y:       set_y = 1'b1;
            LOC_PINDIRS: pins.write_dirs = 1'b1;
            default: ;                             // NULL discards the bits
          endcase
        end
        OP_PUSHPULL: begin
          if (ins.flow.op1[2]) begin               // PULL
            fetch.stall   = blocking && tx_empty;
            pull          = !tx_empty;
            shift.set_osr = !(blocking && tx_empty); // Empty non-blocking takes X
          end else begin
            fetch.stall   = blocking && rx_full;
            push          = !(blocking && rx_full); // Non-blocking may drop data
            shift.set_isr = !(blocking && rx_full);
          end
        end
        OP_MOV: begin
          if (ins.mov.src <= LOC_NULL) begin
            pins.value = mov_val;
            case (ins.mov.dst)
              LOC_PINS: pins.write_pins = 1'b1;
              LOC_X:    set_x = 1'b1;
              LOC_Y:    set_y = 1'b1;
              default: ;
            endcase
            new_x = mov_val;
            new_y = mov_val;
          end
        end
        OP_SET: begin
          new_x = WORD_W'(ins.flow.op2);
          new_y = WORD_W'(ins.flow.op2);
          case (ins.flow.op1)
            LOC_PINS:    pins.write_pins = 1'b1;
            LOC_X:       set_x = 1'b1;
            LOC_Y:       set_y = 1'b1;
            LOC_PINDIRS: pins.write_dirs = 1'b1;
            default: ;
          endcase
        end
        default: ;                                 // WAIT and IRQ behave as NOP
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (en) begin
      if (set_x) begin
        x <= new_x;
      end else if (dec_x) begin
        x <= x - 1'b1;
      end
      if (set_y) begin
        y <= new_y;
      end else if (dec_y) begin
        y <= y - 1'b1;
      end
    end
  end

endmodule

// File: hw/pio_shift_unit.sv
// Input and output shift registers of the PIO machine
// Direction is set per register, shift amount comes from the execute stage

`timescale 1ns/10ps

module pio_shift_unit import pio_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic en,
  input  logic isr_right,                          // ISR shifts toward bit 0
  input  logic osr_right,                          // OSR shifts out from bit 0
  shift_if.shifter shift
);

  logic [WORD_W-1:0]   isr_q;
  logic [WORD_W-1:0]   osr_q;
  logic [5:0]          osr_count_q;
  logic [2*WORD_W-1:0] n_mask_wide;
  logic [WORD_W-1:0]   n_mask;                     // Low bit_count bits set
  logic [2*WORD_W-1:0] isr_wide;
  logic [2*WORD_W-1:0] osr_wide;
  logic [WORD_W-1:0]   isr_next;
  logic [WORD_W-1:0]   osr_next;
  logic [6:0]          count_sum;

  assign n_mask_wide = (64'd1 << shift.bit_count) - 64'd1;
  assign n_mask      = n_mask_wide[WORD_W-1:0];
  assign count_sum   = {1'b0, osr_count_q} + {1'b0, shift.bit_count};

  always_comb begin
    if (isr_right) begin
      isr_wide = {shift.in_src, isr_q} >> shift.bit_count; // New bits enter at the top
      isr_next = isr_wide[WORD_W-1:0];
    end else begin
      isr_wide = {{WORD_W{1'b0}}, isr_q} << shift.bit_count;
      isr_next = isr_wide[WORD_W-1:0] | (shift.in_src & n_mask);
    end
    if (osr_right) begin
      osr_wide       = {{WORD_W{1'b0}}, osr_q} >> shift.bit_count;
      shift.out_bits = osr_q & n_mask;
    end else begin
      osr_wide       = {{WORD_W{1'b0}}, osr_q} << shift.bit_count;
      shift.out_bits = osr_wide[2*WORD_W-1:WORD_W]; // Top bits land right aligned
    end
    osr_next = osr_wide[WORD_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      isr_q       <= '0;
      osr_count_q <= BIT_COUNT_FULL;               // Empty OSR after reset
    end else if (en) begin
      if (shift.set_isr) begin
        isr_q <= shift.isr_val;
      end else if (shift.in_shift) begin
        isr_q <= isr_next;
      end
      if (shift.set_osr) begin
        osr_count_q <= '0;
      end else if (shift.out_shift) begin
        osr_count_q <= (count_sum > BIT_COUNT_FULL) ? BIT_COUNT_FULL : count_sum[5:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      if (shift.set_osr) begin
        osr_q <= shift.osr_val;
      end else if (shift.out_shift) begin
        osr_q <= osr_next;
      end
    end
  end

  assign shift.isr       = isr_q;
  assign shift.osr       = osr_q;
  assign shift.osr_count = osr_count_q;

endmodule

// File: hw/pio_pin_out.sv
// Output pin and direction registers of the PIO machine
// Writes land in the OUT or SET window and wrap around pin 31

`timescale 1ns/10ps

module pio_pin_out import pio_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  pin_if.out                pins,
  input  logic [4:0]        out_base,
  input  logic [5:0]        out_count,
  input  logic [4:0]        set_base,
  input  logic [2:0]        set_count,
  output logic [WORD_W-1:0] output_pins,
  output logic [WORD_W-1:0] pin_dirs,
  output logic [WORD_W-1:0] pins_stb
);

  logic [4:0]          win_base;
  logic [5:0]          win_count;
  logic [2*WORD_W-1:0] low_mask;
  logic [2*WORD_W-1:0] mask_rot;
  logic [2*WORD_W-1:0] val_rot;
  logic [WORD_W-1:0]   win_mask;
  logic [WORD_W-1:0]   win_val;

  always_comb begin
    win_base  = pins.use_set_window ? set_base : out_base;
    win_count = pins.use_set_window ? {3'b000, set_count} : out_count;
    low_mask  = (64'd1 << win_count) - 64'd1;
    mask_rot  = {low_mask[WORD_W-1:0], low_mask[WORD_W-1:0]} << win_base; // Rotate left
    val_rot   = {pins.value, pins.value} << win_base;
  end

  assign win_mask = mask_rot[2*WORD_W-1:WORD_W];
  assign win_val  = val_rot[2*WORD_W-1:WORD_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      output_pins <= '0;
      pin_dirs    <= '0;
      pins_stb    <= '0;
    end else begin
      pins_stb <= (pins.write_pins || pins.write_dirs) ? win_mask : '0; // One cycle pulse
      if (pins.write_pins) begin
        output_pins <= (output_pins & ~win_mask) | (win_val & win_mask);
      end
      if (pins.write_dirs) begin
        pin_dirs <= (pin_dirs & ~win_mask) | (win_val & win_mask);
      end
    end
  end

endmodule

// File: hw/pio_sm_top.sv
// Top level of one PIO state machine with plain ports
// Program store and FIFOs sit outside and use the push, pull and flag handshake

`timescale 1ns/10ps

module pio_sm_top import pio_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               en,
  input  logic [PC_W-1:0]    pend,                 // Last instruction before wrap
  input  logic [PC_W-1:0]    wrap_target,
  input  logic [INSTR_W-1:0] instr_word,
  output logic [PC_W-1:0]    pc,
  input  logic [WORD_W-1:0]  in_pins,
  input  logic [4:0]         in_base,
  input  logic [4:0]         jmp_pin,
  input  logic               isr_right,
  input  logic               osr_right,
  input  logic [4:0]         out_base,
  input  logic [5:0]         out_count,
  input  logic [4:0]         set_base,
  input  logic [2:0]         set_count,
  input  logic [WORD_W-1:0]  tx_data,              // FWFT head of the TX FIFO
  input  logic               tx_empty,
  input  logic               rx_full,
  output logic               pull,
  output logic               push,
  output logic [WORD_W-1:0]  rx_data,
  output logic [WORD_W-1:0]  output_pins,
  output logic [WORD_W-1:0]  pin_dirs,
  output logic [WORD_W-1:0]  pins_stb
);

  fetch_if fetch_bus ();
  shift_if shift_bus ();
  pin_if   pin_bus ();

  pio_fetch u_fetch (
    .clk         (clk),
    .reset       (reset),
    .en          (en),
    .pend        (pend),
    .wrap_target (wrap_target),
    .pc          (pc),
    .instr_word  (instr_word),
    .fetch       (fetch_bus)
  );

  pio_exec u_exec (
    .clk      (clk),
    .reset    (reset),
    .en       (en),
    .fetch    (fetch_bus),
    .shift    (shift_bus),
    .pins     (pin_bus),
    .in_pins  (in_pins),
    .in_base  (in_base),
    .jmp_pin  (jmp_pin),
    .tx_data  (tx_data),
    .tx_empty (tx_empty),
    .rx_full  (rx_full),
    .pull     (pull),
    .push     (push),
    .rx_data  (rx_data)
  );

  pio_shift_unit u_shift (
    .clk       (clk),
    .reset     (reset),
    .en        (en),
    .isr_right (isr_right),
    .osr_right (osr_right),
    .shift     (shift_bus)
  );

  pio_pin_out u_pins (
    .clk         (clk),
    .reset       (reset),
    .pins        (pin_bus),
    .out_base    (out_base),
    .out_count   (out_count),
    .set_base    (set_base),
    .set_count   (set_count),
    .output_pins (output_pins),
    .pin_dirs    (pin_dirs),
    .pins_stb    (pins_stb)
  );

endmodule

// File: sim/pio_tb.sv
// Self-checking testbench for the PIO state machine top level
// Runs short programs from a local program store against TX and RX FIFO models and pin checks

`timescale 1ns/10ps

module pio_tb import pio_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int MAX_STALL    = 8;                 // Longest run of empty or full flags
  localparam int PROG_STEPS   = 60;                // Instructions executed over all tests
  localparam int SETUP_CYCLES = 10;                // Reset, load and drain per test
  localparam int NUM_TESTS    = 8;
  localparam int LIMIT_CYCLES = (PROG_STEPS + NUM_TESTS * SETUP_CYCLES) * MAX_STALL;

  logic               clk;
  logic               reset;
  logic               en;
  logic [PC_W-1:0]    pend;
  logic [PC_W-1:0]    wrap_target;
  logic [INSTR_W-1:0] instr_word;
  logic [PC_W-1:0]    pc;
  logic [WORD_W-1:0]  in_pins;
  logic [4:0]         in_base;
  logic [4:0]         jmp_pin;
  logic               isr_right;
  logic               osr_right;
  logic [4:0]         out_base;
  logic [5:0]         out_count;
  logic [4:0]         set_base;
  logic [2:0]         set_count;
  logic [WORD_W-1:0]  tx_data;
  logic               tx_empty;
  logic               rx_full;
  logic               pull;
  logic               push;
  logic [WORD_W-1:0]  rx_data;
  logic [WORD_W-1:0]  output_pins;
  logic [WORD_W-1:0]  pin_dirs;
  logic [WORD_W-1:0]  pins_stb;

  logic [INSTR_W-1:0] prog [32];                   // Program store, indexed by pc
  logic [31:0]        lfsr_state = 32'he189e986;
  logic [31:0]        tx_head;                     // Word at the head of the TX FIFO
  int                 tx_loaded;
  int                 tx_pulled;
  int                 rx_run;
  int                 tx_run;
  logic [31:0]        ref_pins;
  logic [31:0]        ref_dirs;
  logic [31:0]        push_q[$];
  logic [31:0]        stb_q[$];
  logic [31:0]        out_q[$];
  logic [31:0]        dir_q[$];
  string              test_name;

  pio_sm_top UUT (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [15:0] enc(input logic [2:0] op, input logic [2:0] op1,
                                      input logic [4:0] op2);
    instr_t i;
    i = '0;
    i.flow.op  = op;
    i.flow.op1 = op1;
    i.flow.op2 = op2;
    return i;
  endfunction

  function automatic logic [15:0] enc_mov(input logic [2:0] dst, input logic [1:0] mov_op,
                                          input logic [2:0] src);
    instr_t i;
    i = '0;
    i.mov.op     = OP_MOV;
    i.mov.dst    = dst;
    i.mov.mov_op = mov_op;
    i.mov.src    = src;
    return i;
  endfunction

  function automatic logic [31:0] bit_reverse(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) begin
      r[i] = v[31-i];
    end
    return r;
  endfunction

  // Low n bits when shifting right and top n bits when shifting left
  function automatic logic [31:0] out_slice(input logic [31:0] w, input int n, input logic right);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = right ? w[i] : w[32-n+i];
    end
    return r;
  endfunction

  function automatic logic [31:0] window_mask(input int base, input int count);
    logic [31:0] m;
    m = '0;
    for (int i = 0; i < count; i++) begin
      m[(base + i) % 32] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [31:0] window_place(input logic [31:0] v, input int base,
                                               input int count);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < count; i++) begin
      r[(base + i) % 32] = v[i];
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s failed: %s", test_name, why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_pin_write(input logic [31:0] v, input int base, input int count,
                                  input logic dirs);
    logic [31:0] mask;
    logic [31:0] placed;
    mask   = window_mask(base, count);
    placed = window_place(v, base, count);
    if (dirs) begin
      ref_dirs = (ref_dirs & ~mask) | placed;
    end else begin
      ref_pins = (ref_pins & ~mask) | placed;
    end
    stb_q.push_back(mask);
    out_q.push_back(ref_pins);
    dir_q.push_back(ref_dirs);
  endtask

  task automatic start_test(input string name, input logic [4:0] pend_v,
                            input logic [4:0] wrap_v);
    test_name = name;
    @(posedge clk);
    #2;
    reset       = 1'b1;
    en          = 1'b0;
    pend        = pend_v;
    wrap_target = wrap_v;
    for (int i = 0; i < 32; i++) begin
      prog[i] = enc(OP_JMP, 3'd0, 5'(i));          // Every slot traps on itself
    end
    ref_pins = '0;
    ref_dirs = '0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  task automatic enable_machine();
    @(posedge clk);
    #2;
    en = 1'b1;
  endtask

  task automatic wait_pc(input logic [4:0] target);
    do @(negedge clk); while (pc !== target);
  endtask

  task automatic stop_machine();
    @(posedge clk);
    #2;
    en = 1'b0;
    check_value("pushes left over", 32'd0, 32'(push_q.size()));
    check_value("pin writes left over", 32'd0, 32'(stb_q.size()));
  endtask

  task automatic test_reset_state();
    start_test("reset state", 5'd31, 5'd0);
    @(negedge clk);
    check_value("pc", 32'd0, 32'(pc));
    check_value("push", 32'd0, 32'(push));
    check_value("pull", 32'd0, 32'(pull));
    check_value("output pins", 32'd0, output_pins);
    check_value("pin dirs", 32'd0, pin_dirs);
  endtask

  task automatic test_set_window();
    logic [4:0] d_pins;
    logic [4:0] d_dirs;
    logic [2:0] cnt;
    start_test("set window", 5'd31, 5'd0);
    set_base = 5'(rand_bits(5));
    cnt      = 3'(rand_bits(3));
    if (cnt == 3'd0) begin
      cnt = 3'd7;                                  // Keep the window non-empty
    end
    set_count = cnt;
    d_pins    = 5'(rand_bits(5));
    d_dirs    = 5'(rand_bits(5));
    prog[0]   = enc(OP_SET, LOC_PINS, d_pins);
    prog[1]   = enc(OP_SET, LOC_PINDIRS, d_dirs);
    expect_pin_write(32'(d_pins), int'(set_base), int'(cnt), 1'b0);
    expect_pin_write(32'(d_dirs), int'(set_base), int'(cnt), 1'b1);
    enable_machine();
    wait_pc(5'd2);
    stop_machine();
  endtask

  task automatic test_x_loop();
    start_test("x loop", 5'd4, 5'd6);
    prog[0] = enc(OP_SET, LOC_X, 5'd5);
    prog[1] = enc(OP_IN, LOC_X, 5'd0);             // 32 bits
    prog[2] = enc(OP_PUSHPULL, 3'b001, 5'd0);      // Blocking PUSH
    prog[3] = enc(OP_JMP, 3'd2, 5'd1);             // X-- back to IN
    prog[4] = enc(OP_SET, LOC_Y, 5'd0);
    for (int v = 5; v >= 0; v--) begin
      push_q.push_back(32'(v));
    end
    enable_machine();
    wait_pc(5'd4);
    @(negedge clk);
    check_value("wrap to target", 32'd6, 32'(pc));
    stop_machine();
  endtask

  task automatic test_pull_out(input logic dir);
    logic [31:0] w;
    int          n;
    int          cnt;
    int          base;
    start_test(dir ? "pull out right" : "pull out left", 5'd31, 5'd0);
    w         = rand_bits(32);
    n         = 1 + int'(rand_bits(5));
    cnt       = 1 + int'(rand_bits(5));
    base      = int'(rand_bits(5));
    osr_right = dir;
    out_base  = 5'(base);
    out_count = 6'(cnt);
    tx_head   = w;
    prog[0]   = enc(OP_PUSHPULL, 3'b101, 5'd0);    // Blocking PULL
    prog[1]   = enc(OP_OUT, LOC_PINS, 5'(n));      // 32 encodes as 0
    expect_pin_write(out_slice(w, n, dir), base, cnt, 1'b0);
    enable_machine();
    @(negedge clk);
    tx_loaded = tx_loaded + 1;                     // FIFO stays empty for the first PULL cycle
    while (!pull) begin
      check_value("stalled pc", 32'd0, 32'(pc));
      @(negedge clk);
    end
    wait_pc(5'd2);
    stop_machine();
  endtask

  task automatic test_mov_ops();
    logic [31:0] w;
    start_test("mov ops", 5'd31, 5'd0);
    w         = rand_bits(32);
    osr_right = 1'b1;
    tx_head   = w;
    tx_loaded = tx_loaded + 1;
    prog[0]  = enc(OP_PUSHPULL, 3'b101, 5'd0);
    prog[1]  = enc(OP_OUT, LOC_Y, 5'd0);           // Y gets the pulled word
    prog[2]  = enc_mov(LOC_X, MOV_INVERT, LOC_Y);
    prog[3]  = enc(OP_IN, LOC_X, 5'd0);
    prog[4]  = enc(OP_PUSHPULL, 3'b001, 5'd0);
    prog[5]  = enc_mov(LOC_X, MOV_REVERSE, LOC_Y);
    prog[6]  = enc(OP_IN, LOC_X, 5'd0);
    prog[7]  = enc(OP_PUSHPULL, 3'b001, 5'd0);
    prog[8]  = enc(OP_PUSHPULL, 3'b100, 5'd0);     // Non-blocking PULL on the empty FIFO
    prog[9]  = enc_mov(LOC_X, 2'd0, LOC_Y);        // Overwrite X before reading OSR back
    prog[10] = enc(OP_OUT, LOC_X, 5'd0);
    prog[11] = enc(OP_IN, LOC_X, 5'd0);
    prog[12] = enc(OP_PUSHPULL, 3'b001, 5'd0);
    push_q.push_back(~w);
    push_q.push_back(bit_reverse(w));
    push_q.push_back(bit_reverse(w));              // Former X came back through the OSR
    enable_machine();
    wait_pc(5'd13);
    stop_machine();
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // Program store read and FIFO flags with busy runs below MAX_STALL cycles
  initial begin
    instr_word = '0;
    tx_data    = '0;
    tx_empty   = 1'b1;
    rx_full    = 1'b0;
    rx_run     = 0;
    tx_run     = 0;
    forever begin
      @(posedge clk);
      #2;
      instr_word = prog[pc];
      tx_data    = tx_head;
      if (rand_bits(1) != 0 && rx_run < MAX_STALL - 1) begin
        rx_full = 1'b1;
        rx_run  = rx_run + 1;
      end else begin
        rx_full = 1'b0;
        rx_run  = 0;
      end
      if (tx_loaded == tx_pulled) begin
        tx_empty = 1'b1;
        tx_run   = 0;
      end else if (rand_bits(1) != 0 && tx_run < MAX_STALL - 1) begin
        tx_empty = 1'b1;
        tx_run   = tx_run + 1;
      end else begin
        tx_empty = 1'b0;
        tx_run   = 0;
      end
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      if (pull && tx_empty) begin
        fail_run("pull strobe while the TX FIFO is empty");
      end
      if (push && rx_full) begin
        fail_run("blocking push strobe while the RX FIFO is full");
      end
      if (pull) begin
        tx_pulled = tx_pulled + 1;
      end
      if (push) begin
        if (push_q.size() == 0) begin
          fail_run("push strobe with no push expected");
        end else begin
          check_value("push data", push_q.pop_front(), rx_data);
        end
      end
      if (pins_stb != '0) begin
        if (stb_q.size() == 0) begin
          fail_run("pin write with no write expected");
        end else begin
          check_value("pin strobe", stb_q.pop_front(), pins_stb);
          check_value("output pins", out_q.pop_front(), output_pins);
          check_value("pin dirs", dir_q.pop_front(), pin_dirs);
        end
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             LIMIT_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  end

  initial begin
    reset       = 1'b1;
    en          = 1'b0;
    pend        = 5'd31;
    wrap_target = '0;
    in_pins     = '0;
    in_base     = '0;
    jmp_pin     = '0;
    isr_right   = 1'b0;
    osr_right   = 1'b0;
    out_base    = '0;
    out_count   = '0;
    set_base    = '0;
    set_count   = '0;
    tx_head     = '0;
    tx_loaded   = 0;
    tx_pulled   = 0;
    test_reset_state();
    repeat (3) test_set_window();
    test_x_loop();
    test_pull_out(1'b1);
    test_pull_out(1'b0);
    test_mov_ops();
    @(posedge clk);
    if (push_q.size() == 0 && stb_q.size() == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("Expected pushes or pin writes never appeared");
      $display("ERRORS FOUND");
      $fatal(1, "incomplete run");
    end
  end

endmodule

// File: pio_sm.f
hw/pio_pkg.sv
hw/pio_ifs.sv
hw/pio_fetch.sv
hw/pio_exec.sv
hw/pio_shift_unit.sv
hw/pio_pin_out.sv
hw/pio_sm_top.sv
sim/pio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the PIO state machine testbench with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f pio_sm.f --top-module pio_tb -o pio_sim

# Exit status of the run is checked through the log
./obj_dir/pio_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
